//--- src/fp2_pkg.sv
// Field width, element, tag and control types, Fp unit and Fp2 stream payloads
package fp2_pkg;

  // Width of one Fp element
  localparam int FE_BITS = 16;

  typedef logic [FE_BITS-1:0] fe_t;
  typedef logic [7:0]         tag_t;
  // Real/imaginary half for add and sub, product number for mul
  typedef logic [1:0]         step_t;

  // Control word carried through the Fp units, src is set by the arbiter
  typedef struct packed {
    tag_t  tag;
    step_t step;
    logic  src;
  } ctl_t;

  // Request to an Fp unit
  typedef struct packed {
    fe_t  a;
    fe_t  b;
    ctl_t ctl;
  } fe_pair_t;

  // Response from an Fp unit
  typedef struct packed {
    fe_t  dat;
    ctl_t ctl;
  } fe_res_t;

  typedef struct packed {
    fe_t re;
    fe_t im;
  } fe2_t;

  typedef struct packed {
    fe2_t a;
    fe2_t b;
    tag_t tag;
  } fe2_req_t;

  typedef struct packed {
    fe2_t dat;
    tag_t tag;
  } fe2_res_t;

endpackage

//--- src/fe_add_sub.sv
// Single-cycle modular adder or subtractor with registered output
`timescale 1ns/1ns

module fe_add_sub
  import fp2_pkg::*;
#(
  parameter int P        = 65521,
  parameter bit SUBTRACT = 1'b0
) (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_val,
  output logic     o_rdy,
  input  fe_pair_t i_req,
  output logic     o_val,
  input  logic     i_rdy,
  output fe_res_t  o_res
);

  localparam logic [FE_BITS:0] MOD = P[FE_BITS:0];

  logic [FE_BITS:0] raw;
  logic [FE_BITS:0] fix;
  fe_t              result;

  // One correction by P covers both directions since a, b < P
  always_comb begin
    if (SUBTRACT) begin
      raw    = {1'b0, i_req.a} - {1'b0, i_req.b};
      fix    = raw + MOD;
      // Borrow out of the top bit means a < b
      result = raw[FE_BITS] ? fix[FE_BITS-1:0] : raw[FE_BITS-1:0];
    end else begin
      raw    = {1'b0, i_req.a} + {1'b0, i_req.b};
      fix    = raw - MOD;
      result = (raw >= MOD) ? fix[FE_BITS-1:0] : raw[FE_BITS-1:0];
    end
  end

  assign o_rdy = ~o_val | i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val     <= i_val;
      o_res.dat <= result;
      o_res.ctl <= i_req.ctl;
    end
  end

  // Operands arrive already reduced from the arithmetic block
  a_operands_reduced : assert property (@(posedge i_clk) disable iff (i_rst)
    (i_val && o_rdy) |-> (i_req.a < MOD[FE_BITS-1:0] && i_req.b < MOD[FE_BITS-1:0]));

endmodule

//--- src/fe_mul.sv
// Sequential shift-and-add modular multiplier for Fp elements
`timescale 1ns/1ns

module fe_mul
  import fp2_pkg::*;
#(
  parameter int P = 65521
) (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_val,
  output logic     o_rdy,
  input  fe_pair_t i_req,
  output logic     o_val,
  input  logic     i_rdy,
  output fe_res_t  o_res
);

  localparam int               CNT_BITS = $clog2(FE_BITS + 1);
  localparam logic [FE_BITS:0] MOD      = P[FE_BITS:0];

  typedef enum logic [1:0] {IDLE, RUN, DONE} mul_state_t;

  mul_state_t          state;
  fe_t                 mcand;
  // Multiplier bits, consumed from the top
  fe_t                 mplier;
  fe_t                 acc;
  logic [CNT_BITS-1:0] cnt;
  logic [FE_BITS:0]    dbl;
  logic [FE_BITS:0]    sum;
  fe_t                 dbl_mod;
  fe_t                 acc_next;

  // acc = 2*acc + bit*a, reduced after each term
  always_comb begin
    dbl      = {acc, 1'b0};
    dbl_mod  = (dbl >= MOD) ? fe_t'(dbl - MOD) : fe_t'(dbl);
    sum      = {1'b0, dbl_mod} + (mplier[FE_BITS-1] ? {1'b0, mcand} : '0);
    acc_next = (sum >= MOD) ? fe_t'(sum - MOD) : fe_t'(sum);
  end

  assign o_rdy = (state == IDLE);
  assign o_val = (state == DONE);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (i_val) state <= RUN;
        RUN:     if (cnt == '0) state <= DONE;
        DONE:    if (i_rdy) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // FE_BITS steps, then one more to move acc into the result
  always_ff @(posedge i_clk) begin
    if (state == IDLE && i_val) begin
      mcand     <= i_req.a;
      mplier    <= i_req.b;
      acc       <= '0;
      cnt       <= CNT_BITS'(FE_BITS);
      o_res.ctl <= i_req.ctl;
    end else if (state == RUN) begin
      if (cnt == '0) begin
        o_res.dat <= acc;
      end else begin
        acc    <= acc_next;
        mplier <= mplier << 1;
        cnt    <= cnt - 1'b1;
      end
    end
  end

  a_res_held : assert property (@(posedge i_clk) disable iff (i_rst)
    (o_val && !i_rdy) |=> (o_val && $stable(o_res)));

endmodule

//--- src/fe_res_share.sv
// Two-requester round-robin arbiter in front of one shared Fp unit
`timescale 1ns/1ns

module fe_res_share
  import fp2_pkg::*;
(
  input  logic           i_clk,
  input  logic           i_rst,
  // Requesters
  input  logic     [1:0] i_val,
  output logic     [1:0] o_rdy,
  input  fe_pair_t [1:0] i_req,
  // Shared unit
  output logic           o_unit_val,
  input  logic           i_unit_rdy,
  output fe_pair_t       o_unit_req,
  input  logic           i_unit_val,
  output logic           o_unit_rdy,
  input  fe_res_t        i_unit_res,
  // Responses back to the requesters
  output logic     [1:0] o_val,
  input  logic     [1:0] i_rdy,
  output fe_res_t  [1:0] o_res
);

  logic [1:0] grant;
  // Port that wins when both request
  logic       rr_ptr;
  fe_pair_t   pick;

  always_comb begin
    if (&i_val) begin
      grant = rr_ptr ? 2'b10 : 2'b01;
    end else begin
      grant = i_val;
    end
    pick         = grant[1] ? i_req[1] : i_req[0];
    pick.ctl.src = grant[1];
  end

  assign o_unit_val = |i_val;
  assign o_unit_req = pick;
  assign o_rdy      = grant & {2{i_unit_rdy}};

  // Pass priority to the other port after each transfer
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rr_ptr <= 1'b0;
    end else if (o_unit_val && i_unit_rdy) begin
      rr_ptr <= grant[0];
    end
  end

  // Responses return to the port stamped into ctl.src
  assign o_val      = {i_unit_val & i_unit_res.ctl.src, i_unit_val & ~i_unit_res.ctl.src};
  assign o_res      = {i_unit_res, i_unit_res};
  assign o_unit_rdy = i_rdy[i_unit_res.ctl.src];

  a_grant_onehot : assert property (@(posedge i_clk) disable iff (i_rst)
    $onehot0(grant) && ((grant & ~i_val) == 2'b00));

endmodule

//--- src/fe2_arith.sv
// Fp2 request splitter and result assembler for add, subtract and multiply
`timescale 1ns/1ns

module fe2_arith
  import fp2_pkg::*;
(
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_fp_mode,
  // Fp2 channels
  input  logic           i_add_val,
  output logic           o_add_rdy,
  input  fe2_req_t       i_add_req,
  output logic           o_add_val,
  input  logic           i_add_rdy,
  output fe2_res_t       o_add_res,
  input  logic           i_sub_val,
  output logic           o_sub_rdy,
  input  fe2_req_t       i_sub_req,
  output logic           o_sub_val,
  input  logic           i_sub_rdy,
  output fe2_res_t       o_sub_res,
  input  logic           i_mul_val,
  output logic           o_mul_rdy,
  input  fe2_req_t       i_mul_req,
  output logic           o_mul_val,
  input  logic           i_mul_rdy,
  output fe2_res_t       o_mul_res,
  // Shared Fp multiplier
  output logic           o_fmul_val,
  input  logic           i_fmul_rdy,
  output fe_pair_t       o_fmul_req,
  input  logic           i_fmul_val,
  output logic           o_fmul_rdy,
  input  fe_res_t        i_fmul_res,
  // Adder arbiter, port 0 for add halves, port 1 for mul sums
  output logic     [1:0] o_fadd_val,
  input  logic     [1:0] i_fadd_rdy,
  output fe_pair_t [1:0] o_fadd_req,
  input  logic     [1:0] i_fadd_val,
  output logic     [1:0] o_fadd_rdy,
  input  fe_res_t  [1:0] i_fadd_res,
  // Subtractor arbiter, port 0 for sub halves, port 1 for mul differences
  output logic     [1:0] o_fsub_val,
  input  logic     [1:0] i_fsub_rdy,
  output fe_pair_t [1:0] o_fsub_req,
  input  logic     [1:0] i_fsub_val,
  output logic     [1:0] o_fsub_rdy,
  input  fe_res_t  [1:0] i_fsub_res
);

  typedef enum logic {ADD0, ADD1} add_state_t;
  typedef enum logic {SUB0, SUB1} sub_state_t;
  typedef enum logic [1:0] {MUL0, MUL1, MUL2, MUL3} mul_state_t;

  add_state_t add_state;
  sub_state_t sub_state;
  mul_state_t mul_state;
  logic       fp_mode_add;
  logic       fp_mode_sub;
  logic       fp_mode_mul;

  // Pending requests toward the arbiters
  logic       add_pv, sub_pv, madd_pv, msub_pv;
  fe_pair_t   add_p, sub_p, madd_p, msub_p;
  logic       add_ld, sub_ld, madd_ld, msub_ld, mul_ld;
  logic       add_out_ld, sub_out_ld;
  // Bit 0 holds the sum (imaginary), bit 1 the difference (real)
  logic [1:0] mul_vld;
  logic       mul_out_take;
  logic       fmul_take;
  fe_pair_t   mul_pick;

  assign o_fadd_val = {madd_pv, add_pv};
  assign o_fadd_req = {madd_p, add_p};
  assign o_fsub_val = {msub_pv, sub_pv};
  assign o_fsub_req = {msub_p, sub_p};

  // Addition, one Fp add per half
  assign add_ld        = ~add_pv | i_fadd_rdy[0];
  assign add_out_ld    = ~o_add_val | i_add_rdy;
  assign o_add_rdy     = (fp_mode_add | add_state == ADD1) & add_ld;
  assign o_fadd_rdy[0] = add_out_ld;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      add_state   <= ADD0;
      add_pv      <= 1'b0;
      o_add_val   <= 1'b0;
      fp_mode_add <= 1'b0;
    end else begin
      fp_mode_add <= i_fp_mode;
      if (add_ld) begin
        add_pv <= i_add_val;
        if (add_state == ADD0) begin
          add_p <= '{a: i_add_req.a.re, b: i_add_req.b.re,
                     ctl: '{tag: i_add_req.tag, step: 2'd0, src: 1'b0}};
          if (i_add_val && !fp_mode_add) add_state <= ADD1;
        end else begin
          add_p <= '{a: i_add_req.a.im, b: i_add_req.b.im,
                     ctl: '{tag: i_add_req.tag, step: 2'd1, src: 1'b0}};
          if (i_add_val) add_state <= ADD0;
        end
      end
      // Real half is stored first, the imaginary half completes the result
      if (add_out_ld) begin
        o_add_val <= i_fadd_val[0] & (fp_mode_add | i_fadd_res[0].ctl.step[0]);
        if (i_fadd_val[0] && i_fadd_res[0].ctl.step[0]) begin
          o_add_res.dat.im <= i_fadd_res[0].dat;
        end else if (i_fadd_val[0]) begin
          o_add_res.dat.re <= i_fadd_res[0].dat;
          o_add_res.tag    <= i_fadd_res[0].ctl.tag;
        end
      end
    end
  end

  // Subtraction, same flow on the subtractor
  assign sub_ld        = ~sub_pv | i_fsub_rdy[0];
  assign sub_out_ld    = ~o_sub_val | i_sub_rdy;
  assign o_sub_rdy     = (fp_mode_sub | sub_state == SUB1) & sub_ld;
  assign o_fsub_rdy[0] = sub_out_ld;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      sub_state   <= SUB0;
      sub_pv      <= 1'b0;
      o_sub_val   <= 1'b0;
      fp_mode_sub <= 1'b0;
    end else begin
      fp_mode_sub <= i_fp_mode;
      if (sub_ld) begin
        sub_pv <= i_sub_val;
        if (sub_state == SUB0) begin
          sub_p <= '{a: i_sub_req.a.re, b: i_sub_req.b.re,
                     ctl: '{tag: i_sub_req.tag, step: 2'd0, src: 1'b0}};
          if (i_sub_val && !fp_mode_sub) sub_state <= SUB1;
        end else begin
          sub_p <= '{a: i_sub_req.a.im, b: i_sub_req.b.im,
                     ctl: '{tag: i_sub_req.tag, step: 2'd1, src: 1'b0}};
          if (i_sub_val) sub_state <= SUB0;
        end
      end
      if (sub_out_ld) begin
        o_sub_val <= i_fsub_val[0] & (fp_mode_sub | i_fsub_res[0].ctl.step[0]);
        if (i_fsub_val[0] && i_fsub_res[0].ctl.step[0]) begin
          o_sub_res.dat.im <= i_fsub_res[0].dat;
        end else if (i_fsub_val[0]) begin
          o_sub_res.dat.re <= i_fsub_res[0].dat;
          o_sub_res.tag    <= i_fsub_res[0].ctl.tag;
        end
      end
    end
  end

  // Multiplication (a + bi)(a' + b'i) = (aa' - bb') + (ab' + a'b)i
  always_comb begin
    mul_pick.ctl = '{tag: i_mul_req.tag, step: step_t'(mul_state), src: 1'b0};
    case (mul_state)
      MUL0:    {mul_pick.a, mul_pick.b} = {i_mul_req.a.re, i_mul_req.b.re};
      MUL1:    {mul_pick.a, mul_pick.b} = {i_mul_req.a.im, i_mul_req.b.im};
      MUL2:    {mul_pick.a, mul_pick.b} = {i_mul_req.a.re, i_mul_req.b.im};
      default: {mul_pick.a, mul_pick.b} = {i_mul_req.a.im, i_mul_req.b.re};
    endcase
  end

  assign mul_ld        = ~o_fmul_val | i_fmul_rdy;
  assign o_mul_rdy     = (fp_mode_mul | mul_state == MUL3) & mul_ld;
  assign madd_ld       = ~madd_pv | i_fadd_rdy[1];
  assign msub_ld       = ~msub_pv | i_fsub_rdy[1];
  assign o_mul_val     = &mul_vld;
  assign mul_out_take  = o_mul_val & i_mul_rdy;
  assign o_fadd_rdy[1] = ~mul_vld[0] | mul_out_take;
  assign o_fsub_rdy[1] = ~mul_vld[1] | mul_out_take;
  // Products 0 and 1 feed the difference, 2 and 3 the sum
  assign o_fmul_rdy    = fp_mode_mul ? o_fadd_rdy[1] :
                         (i_fmul_res.ctl.step[1] ? madd_ld : msub_ld);
  assign fmul_take     = i_fmul_val & o_fmul_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mul_state   <= MUL0;
      o_fmul_val  <= 1'b0;
      madd_pv     <= 1'b0;
      msub_pv     <= 1'b0;
      mul_vld     <= 2'b00;
      fp_mode_mul <= 1'b0;
    end else begin
      fp_mode_mul <= i_fp_mode;
      if (mul_ld) begin
        o_fmul_val <= i_mul_val;
        o_fmul_req <= mul_pick;
        if (i_mul_val) mul_state <= fp_mode_mul ? MUL0 : mul_state_t'(mul_state + 1'b1);
      end

      if (madd_pv && i_fadd_rdy[1]) madd_pv <= 1'b0;
      if (msub_pv && i_fsub_rdy[1]) msub_pv <= 1'b0;
      // First product of each pair waits as operand a
      if (fmul_take && !fp_mode_mul) begin
        case (i_fmul_res.ctl.step)
          2'd0: msub_p.a <= i_fmul_res.dat;
          2'd1: begin
            msub_p.b   <= i_fmul_res.dat;
            msub_p.ctl <= i_fmul_res.ctl;
            msub_pv    <= 1'b1;
          end
          2'd2: madd_p.a <= i_fmul_res.dat;
          default: begin
            madd_p.b   <= i_fmul_res.dat;
            madd_p.ctl <= i_fmul_res.ctl;
            madd_pv    <= 1'b1;
          end
        endcase
      end

      if (mul_out_take) mul_vld <= 2'b00;
      if (fp_mode_mul) begin
        if (fmul_take) begin
          o_mul_res.dat.re <= i_fmul_res.dat;
          o_mul_res.tag    <= i_fmul_res.ctl.tag;
          mul_vld          <= 2'b11;
        end
      end else begin
        if (i_fadd_val[1] && o_fadd_rdy[1]) begin
          o_mul_res.dat.im <= i_fadd_res[1].dat;
          o_mul_res.tag    <= i_fadd_res[1].ctl.tag;
          mul_vld[0]       <= 1'b1;
        end
        if (i_fsub_val[1] && o_fsub_rdy[1]) begin
          o_mul_res.dat.re <= i_fsub_res[1].dat;
          mul_vld[1]       <= 1'b1;
        end
      end
    end
  end

endmodule

//--- src/fe2_unit_top.sv
// Fp2 arithmetic unit with its shared Fp multiplier, adder, subtractor and arbiters
`timescale 1ns/1ns

module fe2_unit_top
  import fp2_pkg::*;
#(
  parameter int P = 65521
) (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_fp_mode,
  input  logic     i_add_val,
  output logic     o_add_rdy,
  input  fe2_req_t i_add_req,
  output logic     o_add_val,
  input  logic     i_add_rdy,
  output fe2_res_t o_add_res,
  input  logic     i_sub_val,
  output logic     o_sub_rdy,
  input  fe2_req_t i_sub_req,
  output logic     o_sub_val,
  input  logic     i_sub_rdy,
  output fe2_res_t o_sub_res,
  input  logic     i_mul_val,
  output logic     o_mul_rdy,
  input  fe2_req_t i_mul_req,
  output logic     o_mul_val,
  input  logic     i_mul_rdy,
  output fe2_res_t o_mul_res
);

  // Multiplier stream
  logic           fmul_val, fmul_rdy, fmul_rval, fmul_rrdy;
  fe_pair_t       fmul_req;
  fe_res_t        fmul_res;
  // Requester side of the arbiters
  logic     [1:0] fadd_val, fadd_rdy, fadd_rval, fadd_rrdy;
  fe_pair_t [1:0] fadd_req;
  fe_res_t  [1:0] fadd_res;
  logic     [1:0] fsub_val, fsub_rdy, fsub_rval, fsub_rrdy;
  fe_pair_t [1:0] fsub_req;
  fe_res_t  [1:0] fsub_res;
  // Unit side of the arbiters
  logic           uadd_val, uadd_rdy, uadd_rval, uadd_rrdy;
  fe_pair_t       uadd_req;
  fe_res_t        uadd_res;
  logic           usub_val, usub_rdy, usub_rval, usub_rrdy;
  fe_pair_t       usub_req;
  fe_res_t        usub_res;

  fe2_arith fe2_arith_inst (
    .i_clk, .i_rst, .i_fp_mode,
    .i_add_val, .o_add_rdy, .i_add_req, .o_add_val, .i_add_rdy, .o_add_res,
    .i_sub_val, .o_sub_rdy, .i_sub_req, .o_sub_val, .i_sub_rdy, .o_sub_res,
    .i_mul_val, .o_mul_rdy, .i_mul_req, .o_mul_val, .i_mul_rdy, .o_mul_res,
    .o_fmul_val (fmul_val),  .i_fmul_rdy (fmul_rdy),  .o_fmul_req (fmul_req),
    .i_fmul_val (fmul_rval), .o_fmul_rdy (fmul_rrdy), .i_fmul_res (fmul_res),
    .o_fadd_val (fadd_val),  .i_fadd_rdy (fadd_rdy),  .o_fadd_req (fadd_req),
    .i_fadd_val (fadd_rval), .o_fadd_rdy (fadd_rrdy), .i_fadd_res (fadd_res),
    .o_fsub_val (fsub_val),  .i_fsub_rdy (fsub_rdy),  .o_fsub_req (fsub_req),
    .i_fsub_val (fsub_rval), .o_fsub_rdy (fsub_rrdy), .i_fsub_res (fsub_res)
  );

  fe_mul #(.P(P)) fe_mul_inst (
    .i_clk, .i_rst,
    .i_val (fmul_val),  .o_rdy (fmul_rdy),  .i_req (fmul_req),
    .o_val (fmul_rval), .i_rdy (fmul_rrdy), .o_res (fmul_res)
  );

  fe_res_share add_share_inst (
    .i_clk, .i_rst,
    .i_val      (fadd_val),  .o_rdy      (fadd_rdy),  .i_req      (fadd_req),
    .o_unit_val (uadd_val),  .i_unit_rdy (uadd_rdy),  .o_unit_req (uadd_req),
    .i_unit_val (uadd_rval), .o_unit_rdy (uadd_rrdy), .i_unit_res (uadd_res),
    .o_val      (fadd_rval), .i_rdy      (fadd_rrdy), .o_res      (fadd_res)
  );

  fe_add_sub #(.P(P), .SUBTRACT(1'b0)) fe_add_inst (
    .i_clk, .i_rst,
    .i_val (uadd_val),  .o_rdy (uadd_rdy),  .i_req (uadd_req),
    .o_val (uadd_rval), .i_rdy (uadd_rrdy), .o_res (uadd_res)
  );

  fe_res_share sub_share_inst (
    .i_clk, .i_rst,
    .i_val      (fsub_val),  .o_rdy      (fsub_rdy),  .i_req      (fsub_req),
    .o_unit_val (usub_val),  .i_unit_rdy (usub_rdy),  .o_unit_req (usub_req),
    .i_unit_val (usub_rval), .o_unit_rdy (usub_rrdy), .i_unit_res (usub_res),
    .o_val      (fsub_rval), .i_rdy      (fsub_rrdy), .o_res      (fsub_res)
  );

  fe_add_sub #(.P(P), .SUBTRACT(1'b1)) fe_sub_inst (
    .i_clk, .i_rst,
    .i_val (usub_val),  .o_rdy (usub_rdy),  .i_req (usub_req),
    .o_val (usub_rval), .i_rdy (usub_rrdy), .o_res (usub_res)
  );

endmodule

//--- testbench/tb_fe2_unit.sv
// Directed testbench for the Fp2 unit with a modular reference model and result checks
`timescale 1ns/1ns

module tb_fe2_unit
  import fp2_pkg::*;
();

  localparam int          P          = 65521;
  localparam int          CLK_PERIOD = 40;
  localparam logic [31:0] SEED       = 32'hcfce_9292;
  localparam int          CH_ADD     = 0;
  localparam int          CH_SUB     = 1;
  localparam int          CH_MUL     = 2;
  localparam int          N_ADD      = 50;
  localparam int          N_SUB      = 40;
  localparam int          N_MUL      = 30;
  localparam int          N_FP       = 8;
  localparam int          N_CONC     = 20;
  // Requests issued over all tests including edge cases and the reset test
  localparam int N_REQ      = N_ADD + 2 + N_SUB + 3 + N_MUL + 1 + 3 * N_FP + 3 * N_CONC + 4;
  localparam int MAX_CYCLES = 200 * N_REQ + 1000;

  logic       i_clk;
  logic       i_rst;
  logic       i_fp_mode;
  // Channel signals indexed by CH_ADD, CH_SUB, CH_MUL
  logic [2:0] req_val = 3'b000;
  logic [2:0] req_rdy;
  fe2_req_t   req_in [3];
  logic [2:0] res_val;
  logic [2:0] res_rdy = 3'b111;
  fe2_res_t   res_out [3];

  fe2_res_t   exp_q [3][$];
  tag_t       next_tag [3];
  int         errors  = 0;
  int         checks  = 0;
  int         cycles  = 0;
  bit         fp_only = 1'b0;
  // Random ready on the result side
  bit         bp_on   = 1'b0;

  fe2_unit_top #(.P(P)) fe2_unit_top_inst (
    .i_clk, .i_rst, .i_fp_mode,
    .i_add_val (req_val[CH_ADD]), .o_add_rdy (req_rdy[CH_ADD]), .i_add_req (req_in[CH_ADD]),
    .o_add_val (res_val[CH_ADD]), .i_add_rdy (res_rdy[CH_ADD]), .o_add_res (res_out[CH_ADD]),
    .i_sub_val (req_val[CH_SUB]), .o_sub_rdy (req_rdy[CH_SUB]), .i_sub_req (req_in[CH_SUB]),
    .o_sub_val (res_val[CH_SUB]), .i_sub_rdy (res_rdy[CH_SUB]), .o_sub_res (res_out[CH_SUB]),
    .i_mul_val (req_val[CH_MUL]), .o_mul_rdy (req_rdy[CH_MUL]), .i_mul_req (req_in[CH_MUL]),
    .o_mul_val (res_val[CH_MUL]), .i_mul_rdy (res_rdy[CH_MUL]), .o_mul_res (res_out[CH_MUL])
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // Reference arithmetic mod P on 64-bit integers
  function automatic fe_t mod_add(input fe_t x, input fe_t y);
    longint s;
    s = (longint'(x) + longint'(y)) % P;
    return fe_t'(s);
  endfunction

  function automatic fe_t mod_sub(input fe_t x, input fe_t y);
    longint s;
    s = (longint'(x) - longint'(y) + P) % P;
    return fe_t'(s);
  endfunction

  function automatic fe_t mod_mul(input fe_t x, input fe_t y);
    longint s;
    s = (longint'(x) * longint'(y)) % P;
    return fe_t'(s);
  endfunction

  function automatic fe2_t model_op(input int ch, input fe2_t a, input fe2_t b, input bit fp);
    fe2_t r;
    case (ch)
      CH_ADD: begin
        r.re = mod_add(a.re, b.re);
        r.im = mod_add(a.im, b.im);
      end
      CH_SUB: begin
        r.re = mod_sub(a.re, b.re);
        r.im = mod_sub(a.im, b.im);
      end
      default: begin
        if (fp) begin
          r.re = mod_mul(a.re, b.re);
          r.im = '0;
        end else begin
          r.re = mod_sub(mod_mul(a.re, b.re), mod_mul(a.im, b.im));
          r.im = mod_add(mod_mul(a.re, b.im), mod_mul(a.im, b.re));
        end
      end
    endcase
    return r;
  endfunction

  function automatic fe2_t mk_fe2(input int re, input int im);
    fe2_t r;
    r.re = fe_t'(re);
    r.im = fe_t'(im);
    return r;
  endfunction

  function automatic fe2_t rand_fe2();
    return mk_fe2($urandom_range(P - 1, 0), $urandom_range(P - 1, 0));
  endfunction

  function automatic string ch_name(input int ch);
    case (ch)
      CH_ADD:  return "add";
      CH_SUB:  return "sub";
      default: return "mul";
    endcase
  endfunction

  task automatic check_fe2_res(input fe2_res_t got, input fe2_res_t exp, input bit re_only,
                               input string what);
    checks++;
    if (got.dat.re !== exp.dat.re || (!re_only && got.dat.im !== exp.dat.im)) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s result %0d + %0di, expected %0d + %0di",
               $time, what, got.dat.re, got.dat.im, exp.dat.re, exp.dat.im);
    end
  endtask

  task automatic check_tag(input tag_t got, input tag_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s tag 0x%02h, expected 0x%02h",
               $time, what, got, exp);
    end
  endtask

  task automatic check_idle();
    checks++;
    if (res_val !== 3'b000) begin
      errors++;
      $display("CHECK FAILED at %0t ns: valid (mul, sub, add) %b after reset, expected 000",
               $time, res_val);
    end
  endtask

  // Holds the request until the DUT takes it, then queues the expected result
  task automatic send_req(input int ch, input fe2_t a, input fe2_t b);
    fe2_req_t req;
    fe2_res_t exp;
    logic     taken;
    req.a        = a;
    req.b        = b;
    req.tag      = next_tag[ch];
    next_tag[ch] = next_tag[ch] + 1'b1;
    exp.dat      = model_op(ch, a, b, fp_only);
    exp.tag      = req.tag;
    req_in[ch]   = req;
    req_val[ch]  = 1'b1;
    taken        = 1'b0;
    while (!taken) begin
      #(CLK_PERIOD / 4);
      taken = req_rdy[ch];
      @(negedge i_clk);
    end
    req_val[ch] = 1'b0;
    exp_q[ch].push_back(exp);
  endtask

  task automatic send_stream(input int ch, input int n);
    repeat (n) send_req(ch, rand_fe2(), rand_fe2());
  endtask

  task automatic collect_res(input int ch, input fe2_res_t res);
    fe2_res_t exp;
    if (exp_q[ch].size() == 0) begin
      errors++;
      $display("Unexpected %s result at %0t ns with no request outstanding", ch_name(ch), $time);
    end else begin
      exp = exp_q[ch].pop_front();
      check_fe2_res(res, exp, fp_only, ch_name(ch));
      check_tag(res.tag, exp.tag, ch_name(ch));
    end
  endtask

  task automatic wait_idle();
    while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0) @(negedge i_clk);
    repeat (2) @(negedge i_clk);
  endtask

  // Result side ready changes on the falling edge and outputs are sampled mid low phase
  always @(negedge i_clk) begin : result_monitor
    int k;
    for (k = 0; k < 3; k++) begin
      res_rdy[k] = bp_on ? 1'($urandom_range(1, 0)) : 1'b1;
    end
    #(CLK_PERIOD / 4);
    if (!i_rst) begin
      for (k = 0; k < 3; k++) begin
        if (res_val[k] && res_rdy[k]) collect_res(k, res_out[k]);
      end
    end
  end

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic test_add();
    send_stream(CH_ADD, N_ADD);
    send_req(CH_ADD, mk_fe2(P - 1, P - 1), mk_fe2(P - 1, P - 1));
    send_req(CH_ADD, mk_fe2(0, 0), mk_fe2(0, 0));
    wait_idle();
  endtask

  task automatic test_sub();
    send_stream(CH_SUB, N_SUB);
    // Differences that wrap below zero
    send_req(CH_SUB, mk_fe2(0, 5), mk_fe2(P - 1, 6));
    send_req(CH_SUB, mk_fe2(1, 0), mk_fe2(2, P - 1));
    send_req(CH_SUB, mk_fe2(P - 1, P - 1), mk_fe2(P - 1, P - 1));
    wait_idle();
  endtask

  task automatic test_mul();
    send_stream(CH_MUL, N_MUL);
    // i * i lands on P-1 + 0i
    send_req(CH_MUL, mk_fe2(0, 1), mk_fe2(0, 1));
    wait_idle();
  endtask

  task automatic test_fp_mode();
    repeat (3) @(negedge i_clk);
    i_fp_mode = 1'b1;
    fp_only   = 1'b1;
    repeat (3) @(negedge i_clk);
    fork
      send_stream(CH_ADD, N_FP);
      send_stream(CH_SUB, N_FP);
      send_stream(CH_MUL, N_FP);
    join
    wait_idle();
    i_fp_mode = 1'b0;
    fp_only   = 1'b0;
    repeat (3) @(negedge i_clk);
  endtask

  task automatic test_concurrent();
    bp_on = 1'b1;
    fork
      send_stream(CH_ADD, N_CONC);
      send_stream(CH_SUB, N_CONC);
      send_stream(CH_MUL, N_CONC);
    join
    wait_idle();
    bp_on = 1'b0;
  endtask

  task automatic test_reset();
    int k;
    send_req(CH_MUL, rand_fe2(), rand_fe2());
    send_req(CH_ADD, rand_fe2(), rand_fe2());
    // Both requests are still in flight here
    i_rst = 1'b1;
    for (k = 0; k < 3; k++) begin
      exp_q[k].delete();
    end
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    check_idle();
    send_req(CH_MUL, rand_fe2(), rand_fe2());
    send_req(CH_ADD, rand_fe2(), rand_fe2());
    wait_idle();
  endtask

  initial begin : main_sequence
    int k;
    void'($urandom(SEED));
    i_rst     = 1'b1;
    i_fp_mode = 1'b0;
    for (k = 0; k < 3; k++) begin
      req_in[k]   = '0;
      next_tag[k] = tag_t'(8'h10 * (k + 1));
    end
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    check_idle();

    test_add();
    test_sub();
    test_mul();
    test_fp_mode();
    test_concurrent();
    test_reset();

    $display("Checks run: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
src/fp2_pkg.sv
src/fe_add_sub.sv
src/fe_mul.sv
src/fe_res_share.sv
src/fe2_arith.sv
src/fe2_unit_top.sv
testbench/tb_fe2_unit.sv

//--- Makefile
# Verilator build and run for the Fp2 unit testbench

VERILATOR ?= verilator
TOP       ?= tb_fe2_unit
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Result: PASSED

SOURCES := $(wildcard src/*.sv testbench/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
